// ==== common/icache_pkg.sv ====
// Instruction cache shared definitions.
// Widths, address field layout, tag and lookup records, controller states.

`default_nettype none

package icache_pkg;

    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;                           // Byte offset within a line.
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 23 bits.
    localparam int AGE_W    = 3;
    localparam int AGE_MAX  = 7;                           // Age counters stop here.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [AGE_W-1:0]   age_t;
    typedef logic               way_t;

    // Fetch address split into its fields, most significant first.
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic       word;     // Selects the upper instruction of the line.
        logic [1:0] byte_off;
    } fetch_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
    } lookup_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        REREAD
    } icache_state_e;

endpackage

`default_nettype wire

// ==== logic/way_age.sv ====
// Per-set age counters for victim choice.
// Every delivery ages all lines and renews the one that was used.

`default_nettype none

module way_age (
    input  logic               clk,
    input  logic               reset_i,
    input  icache_pkg::index_t index_i,
    input  logic               deliver_i,
    input  icache_pkg::way_t   access_way_i,
    output icache_pkg::way_t   older_way_o
);
    import icache_pkg::*;

    age_t age_q [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (deliver_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (index_t'(s) == index_i && way_t'(w) == access_way_i) begin
                        age_q[s][w] <= '0;
                    end else if (age_q[s][w] != age_t'(AGE_MAX)) begin
                        age_q[s][w] <= age_q[s][w] + age_t'(1);
                    end
                end
            end
        end
    end

    // Ties go to way 0.
    assign older_way_o = (age_q[index_i][0] >= age_q[index_i][1]) ? way_t'(0) : way_t'(1);

endmodule

`default_nettype wire

// ==== logic/fence_sweep.sv ====
// Fence invalidation sweep.
// Steps through one set per cycle while the fence is held, then waits.

`default_nettype none

module fence_sweep (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fence_i,
    output logic               sweep_en_o,
    output icache_pkg::index_t sweep_index_o
);
    import icache_pkg::*;

    localparam logic [INDEX_W:0] LAST = (INDEX_W+1)'(NUM_SETS);

    logic [INDEX_W:0] count_q;

    always_ff @(posedge clk) begin
        if (reset_i || !fence_i) begin
            count_q <= '0;
        end else if (count_q != LAST) begin
            count_q <= count_q + 1'b1;             // Stops once every set is done.
        end
    end

    assign sweep_en_o    = fence_i && (count_q < LAST);
    assign sweep_index_o = count_q[INDEX_W-1:0];

endmodule

`default_nettype wire

// ==== icache/icache_tags.sv ====
// Two-way tag store.
// Holds a tag and a valid bit per way and set, compares both ways against
// the requested tag and picks the way to refill.

`default_nettype none

module icache_tags (
    input  logic                clk,
    input  logic                reset_i,
    input  icache_pkg::index_t  read_index_i,
    input  icache_pkg::tag_t    req_tag_i,
    input  logic                fill_i,
    input  icache_pkg::way_t    fill_way_i,
    input  icache_pkg::way_t    victim_way_i,
    input  logic                sweep_en_i,
    input  icache_pkg::index_t  sweep_index_i,
    output icache_pkg::lookup_t lookup_o
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    tag_t                tag_mem [NUM_WAYS][NUM_SETS];
    tag_entry_t          entry_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] match;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;                      // Cache starts empty.
            end
        end else if (sweep_en_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w][sweep_index_i] <= 1'b0;
            end
        end else if (fill_i) begin
            valid_q[fill_way_i][read_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[fill_way_i][read_index_i] <= req_tag_i;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            entry_q[w].valid <= valid_q[w][read_index_i];
            entry_q[w].tag   <= tag_mem[w][read_index_i];
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = entry_q[w].valid && (entry_q[w].tag == req_tag_i);
        end
    end

    assign lookup_o.hit     = |match;
    assign lookup_o.hit_way = way_t'(match[1]);

    // An empty way is filled before any resident line is replaced.
    assign lookup_o.victim_way = !entry_q[0].valid ? way_t'(0) :
                                 !entry_q[1].valid ? way_t'(1) : victim_way_i;

endmodule

`default_nettype wire

// ==== icache/icache_data.sv ====
// Line data store.
// One line per way and set, written one way at a time, read as a whole set,
// then narrowed to the requested instruction.

`default_nettype none

module icache_data (
    input  logic               clk,
    input  icache_pkg::index_t read_index_i,
    input  logic               word_i,
    input  icache_pkg::way_t   hit_way_i,
    input  logic               fill_i,
    input  icache_pkg::way_t   fill_way_i,
    input  icache_pkg::line_t  fill_line_i,
    output icache_pkg::inst_t  inst_o
);
    import icache_pkg::*;

    line_t [NUM_WAYS-1:0] mem_q [NUM_SETS];
    line_t [NUM_WAYS-1:0] rd_q;
    line_t                sel_line;

    always_ff @(posedge clk) begin
        if (fill_i) begin
            mem_q[read_index_i][fill_way_i] <= fill_line_i;
        end
        rd_q <= mem_q[read_index_i];               // Old contents on a same-edge fill.
    end

    assign sel_line = rd_q[hit_way_i];

    // Word bit set picks the instruction at the higher address.
    assign inst_o = word_i ? sel_line[LINE_W-1:INST_W] : sel_line[INST_W-1:0];

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
// Cache controller FSM.
// Sequences lookup, line refill from memory, the re-read of the filled set
// and the delivery of the instruction to the core.

`default_nettype none

module icache_ctrl (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                fetch_req_i,
    input  icache_pkg::addr_t   fetch_addr_i,
    input  icache_pkg::lookup_t lookup_i,
    input  logic                mem_valid_i,
    output logic                fetch_valid_o,
    output logic                mem_read_o,
    output icache_pkg::addr_t   mem_addr_o,
    output icache_pkg::index_t  read_index_o,
    output logic                fill_o,
    output logic                deliver_o,
    output icache_pkg::way_t    access_way_o
);
    import icache_pkg::*;

    icache_state_e state_q;
    icache_state_e state_d;
    fetch_addr_t   req;
    logic          hit_now;

    assign req = fetch_addr_t'(fetch_addr_i);

    // The core holds the address, so the stores keep reading the same set.
    assign read_index_o = req.index;
    assign mem_addr_o   = {fetch_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = lookup_i.hit ? IDLE : REFILL;
            end
            REFILL: begin
                if (mem_valid_i) begin
                    state_d = REREAD;              // Line and tag are written here.
                end
            end
            REREAD: begin
                state_d = LOOKUP;                  // Set read again, now hits.
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hit_now       = (state_q == LOOKUP) && lookup_i.hit;
    assign fetch_valid_o = hit_now;
    assign deliver_o     = hit_now;
    assign mem_read_o    = (state_q == REFILL);
    assign fill_o        = (state_q == REFILL) && mem_valid_i;

    // The filled way on a refill, the delivering way otherwise.
    assign access_way_o = fill_o ? lookup_i.victim_way : lookup_i.hit_way;

endmodule

`default_nettype wire

// ==== icache/icache_top.sv ====
// Two-way set-associative instruction cache.
// Joins the controller, the tag and data stores, the age table and the
// fence sweep.

`default_nettype none

module icache_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_req_i,
    input  icache_pkg::addr_t  fetch_addr_i,
    input  logic               fence_i,
    input  logic               mem_valid_i,
    input  icache_pkg::line_t  mem_data_i,
    output logic               fetch_valid_o,
    output icache_pkg::inst_t  fetch_data_o,
    output logic               mem_read_o,
    output icache_pkg::addr_t  mem_addr_o
);
    import icache_pkg::*;

    fetch_addr_t req_addr;
    lookup_t     lookup;
    index_t      read_index;
    logic        fill;
    logic        deliver;
    way_t        access_way;
    way_t        older_way;
    logic        sweep_en;
    index_t      sweep_index;

    assign req_addr = fetch_addr_t'(fetch_addr_i);

    icache_ctrl u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .lookup_i      (lookup),
        .mem_valid_i   (mem_valid_i),
        .fetch_valid_o (fetch_valid_o),
        .mem_read_o    (mem_read_o),
        .mem_addr_o    (mem_addr_o),
        .read_index_o  (read_index),
        .fill_o        (fill),
        .deliver_o     (deliver),
        .access_way_o  (access_way)
    );

    icache_tags u_tags (
        .clk           (clk),
        .reset_i       (reset_i),
        .read_index_i  (read_index),
        .req_tag_i     (req_addr.tag),
        .fill_i        (fill),
        .fill_way_i    (access_way),
        .victim_way_i  (older_way),
        .sweep_en_i    (sweep_en),
        .sweep_index_i (sweep_index),
        .lookup_o      (lookup)
    );

    icache_data u_data (
        .clk          (clk),
        .read_index_i (read_index),
        .word_i       (req_addr.word),
        .hit_way_i    (lookup.hit_way),
        .fill_i       (fill),
        .fill_way_i   (access_way),
        .fill_line_i  (mem_data_i),
        .inst_o       (fetch_data_o)
    );

    way_age u_age (
        .clk          (clk),
        .reset_i      (reset_i),
        .index_i      (read_index),
        .deliver_i    (deliver),
        .access_way_i (access_way),
        .older_way_o  (older_way)
    );

    fence_sweep u_fence (
        .clk           (clk),
        .reset_i       (reset_i),
        .fence_i       (fence_i),
        .sweep_en_o    (sweep_en),
        .sweep_index_o (sweep_index)
    );

endmodule

`default_nettype wire

// ==== verification/icache_asserts.sv ====
// Instruction cache timing checks.
// Core-side hit latency and pulse rules, memory-side hold rules, reset state.

`default_nettype none

module icache_asserts (
    input logic              clk,
    input logic              reset_i,
    input logic              fetch_req_i,
    input logic              fetch_valid_i,
    input logic              lookup_hit_i,
    input logic              mem_read_i,
    input logic              mem_valid_i,
    input icache_pkg::addr_t mem_addr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;
    logic        idle_q;
    logic        first_lookup_q;                   // First cycle after a request is taken.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idle_q         <= 1'b1;
            first_lookup_q <= 1'b0;
        end else begin
            first_lookup_q <= idle_q && fetch_req_i;
            if (idle_q && fetch_req_i) begin
                idle_q <= 1'b0;
            end else if (fetch_valid_i) begin
                idle_q <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hit_latency: assert property (@(posedge clk) disable iff (reset_i)
        first_lookup_q && lookup_hit_i |-> fetch_valid_i)
    else begin
        fail_count++;
        $error("hit not delivered one cycle after the request was taken");
    end

    miss_reads: assert property (@(posedge clk) disable iff (reset_i)
        first_lookup_q && !lookup_hit_i |=> mem_read_i)
    else begin
        fail_count++;
        $error("miss did not start a memory read in the next cycle");
    end

    valid_pulse: assert property (@(posedge clk) disable iff (reset_i)
        fetch_valid_i |=> !fetch_valid_i)
    else begin
        fail_count++;
        $error("fetch_valid_o lasted more than one cycle");
    end

    read_held: assert property (@(posedge clk) disable iff (reset_i)
        mem_read_i && !mem_valid_i |=> mem_read_i && $stable(mem_addr_i))
    else begin
        fail_count++;
        $error("memory read dropped or its address moved before mem_valid_i");
    end

    quiet_after_reset: assert property (@(posedge clk)
        reset_i |=> !fetch_valid_i && !mem_read_i)
    else begin
        fail_count++;
        $error("outputs active right after reset");
    end

endmodule

`default_nettype wire

// ==== verification/icache_tb.sv ====
// Instruction cache testbench.
// Drives fetches and fences into the cache, answers refills from a memory model
// with random delays and checks delivered instructions and memory read counts.

`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int FETCH_LIMIT = 40;
    // About 30 fetches of at most 15 cycles, a 70 cycle fence and reset, with margin.
    localparam int WATCHDOG_CYCLES = 2000;

    localparam addr_t LINE_X = 32'h0004_0104;   // Set 32, upper word.
    localparam addr_t LINE_A = 32'h0000_1028;   // Set 5, tag 8.
    localparam addr_t LINE_B = 32'h0000_2028;   // Set 5, tag 16.
    localparam addr_t LINE_C = 32'h0000_3028;   // Set 5, tag 24.

    logic  clk;
    logic  reset;
    logic  fetch_req;
    addr_t fetch_addr;
    logic  fence;
    logic  mem_valid = 1'b0;
    line_t mem_data  = '0;
    logic  fetch_valid;
    inst_t fetch_data;
    logic  mem_read;
    addr_t mem_addr;

    logic [31:0] lcg_state = 32'hd16b;
    logic        mem_busy  = 1'b0;
    logic [2:0]  wait_left = 3'd0;
    addr_t       last_read_addr = '0;
    int          read_count = 0;
    int          checks = 0;
    int          errors = 0;

    icache_top dut (
        .clk           (clk),
        .reset_i       (reset),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fence_i       (fence),
        .mem_valid_i   (mem_valid),
        .mem_data_i    (mem_data),
        .fetch_valid_o (fetch_valid),
        .fetch_data_o  (fetch_data),
        .mem_read_o    (mem_read),
        .mem_addr_o    (mem_addr)
    );

    bind icache_top icache_asserts u_asserts (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_valid_i (fetch_valid_o),
        .lookup_hit_i  (lookup.hit),
        .mem_read_i    (mem_read_o),
        .mem_valid_i   (mem_valid_i),
        .mem_addr_i    (mem_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [2:0] next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[18:16];
    endfunction

    // Memory holds the line address in the upper half, its inverse below.
    function automatic inst_t expected_inst(input addr_t addr);
        addr_t line_addr;
        line_addr = {addr[31:3], 3'b000};
        return addr[2] ? line_addr : ~line_addr;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            mem_valid <= 1'b0;
            if (mem_read && !mem_busy && !mem_valid) begin
                mem_busy = 1'b1;
                wait_left = next_delay();
                last_read_addr = mem_addr;
                read_count++;
            end
            if (mem_busy) begin
                if (wait_left == 3'd0) begin
                    mem_valid <= 1'b1;
                    mem_data  <= {last_read_addr, ~last_read_addr};
                    mem_busy = 1'b0;
                end else begin
                    wait_left = wait_left - 3'd1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_fetch(input addr_t addr, input int exp_reads);
        int    reads_before;
        int    cycles;
        inst_t got;
        reads_before = read_count;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!fetch_valid && cycles < FETCH_LIMIT);
        got = fetch_data;
        fetch_req <= 1'b0;
        checks++;
        assert (fetch_valid) else begin
            $display("Fetch of %h got no response within %0d cycles", addr, FETCH_LIMIT);
            errors++;
        end
        if (fetch_valid) begin
            assert (got == expected_inst(addr)) else begin
                $display("[ERROR] %0t: fetch %h returned %h, expected %h",
                         $time, addr, got, expected_inst(addr));
                errors++;
            end
            assert (read_count - reads_before == exp_reads) else begin
                $display("[ERROR] %0t: fetch %h made %0d memory reads, expected %0d",
                         $time, addr, read_count - reads_before, exp_reads);
                errors++;
            end
            if (exp_reads == 1) begin
                assert (last_read_addr == {addr[31:3], 3'b000}) else begin
                    $display("[ERROR] %0t: refill of %h read %h", $time, addr, last_read_addr);
                    errors++;
                end
            end
            if (exp_reads == 0) begin
                // The pulse comes one cycle after the sampling edge.
                assert (cycles == 2) else begin
                    $display("[ERROR] %0t: hit on %h took %0d cycles", $time, addr, cycles - 1);
                    errors++;
                end
            end
        end
    endtask

    task automatic hold_fence(input int num_cycles);
        @(posedge clk);
        fence <= 1'b1;
        repeat (num_cycles) @(posedge clk);
        fence <= 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("[test %0d] %s: %0d errors", num, name, errors - errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int mark;
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        fence      = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        mark = errors;
        check_fetch(LINE_X, 1);
        report_test(1, "cold miss", mark);

        mark = errors;
        check_fetch(LINE_X, 0);
        check_fetch(LINE_X - 32'd4, 0);                // Lower word of the same line.
        report_test(2, "hit", mark);

        mark = errors;
        check_fetch(LINE_A, 1);
        check_fetch(LINE_B, 1);
        check_fetch(LINE_A, 0);
        check_fetch(LINE_B + 32'd4, 0);
        report_test(3, "two ways", mark);

        mark = errors;
        check_fetch(LINE_A, 0);
        check_fetch(LINE_B, 0);
        check_fetch(LINE_A, 0);
        check_fetch(LINE_C, 1);                        // B is the older way here.
        check_fetch(LINE_A, 0);
        check_fetch(LINE_B, 1);
        report_test(4, "replacement", mark);

        mark = errors;
        hold_fence(70);
        check_fetch(LINE_X, 1);
        check_fetch(LINE_A, 1);
        check_fetch(LINE_B, 1);
        check_fetch(LINE_X, 0);
        report_test(5, "fence", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            check_fetch(32'h0010_0000 + 32'(i) * 32'h4c, 1);
        end
        report_test(6, "back-pressure", mark);

        repeat (4) @(posedge clk);
        $display("Summary: %0d fetches, %0d errors, %0d assertion failures",
                 checks, errors, dut.u_asserts.fail_count);
        if (errors == 0 && dut.u_asserts.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/icache_pkg.sv
logic/way_age.sv
logic/fence_sweep.sv
icache/icache_tags.sv
icache/icache_data.sv
icache/icache_ctrl.sv
icache/icache_top.sv
verification/icache_asserts.sv
verification/icache_tb.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench.

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
